//--- dv/pipe_ctrl_properties.sv
module pipe_ctrl_properties #(
    parameter int QUEUE_DEPTH = 4,
    parameter int CNT_W       = $clog2(QUEUE_DEPTH + 1)
) (
    input logic             clk,
    input logic             rst_n,
    input logic [CNT_W-1:0] queue_count,
    input logic             id_valid,
    input logic             id_advance,
    input logic             credit_return,
    input logic             issue_valid,
    input logic             bubble
);

    // credit loop keeps the fill within depth
    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        queue_count <= QUEUE_DEPTH)
        else $error("queue count %0d above depth %0d", queue_count, QUEUE_DEPTH);

    // load moves to MEM after one stall, so never two bubbles in a row
    a_single_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        bubble |=> !bubble)
        else $error("bubble held for two cycles");

    // stalled ID loads nothing and so returns nothing
    a_no_credit_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (id_valid && !id_advance) |-> !credit_return)
        else $error("credit returned while ID is stalled");

    // a bubble cycle carries no instruction
    a_bubble_empty: assert property (@(posedge clk) disable iff (!rst_n)
        bubble |-> !issue_valid)
        else $error("bubble together with issue_valid");

endmodule

bind pipe_ctrl_top pipe_ctrl_properties #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
) u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .queue_count   (u_queue.count),
    .id_valid      (id_valid),
    .id_advance    (id_advance),
    .credit_return (credit_return),
    .issue_valid   (issue_valid),
    .bubble        (bubble)
);

//--- dv/pipe_ctrl_stimulus.txt
// word fwd_a fwd_a_sel fwd_b fwd_b_sel bubble_before gap_allowed
// forwarding chains, nearest writer wins
00500093 0 0 0 0 0 1
00700113 0 0 0 0 0 0
002081B3 1 1 1 0 0 0
00118233 1 0 1 2 0 0
004102B3 1 2 1 0 0 0
00100313 0 0 0 0 0 0
00230313 1 0 0 0 0 0
00330313 1 0 0 0 0 0
006303B3 1 0 1 0 0 0
00730533 1 1 1 0 0 0
// x0 writes, store and branch producers, lui auipc jal consumers
00100013 0 0 0 0 0 1
000005B3 0 0 0 0 0 0
00002723 0 0 0 0 0 0
00000763 0 0 0 0 0 0
00E707B3 0 0 0 0 0 0
00078837 0 0 0 0 0 0
00080897 0 0 0 0 0 0
0008896F 0 0 0 0 0 0
01200993 0 0 0 0 0 0
01280A33 0 0 1 1 0 0
// load-use and load two ahead
00002A83 0 0 0 0 0 1
000A8B33 1 1 0 0 1 0
001B0B93 1 0 0 0 0 0
00402C03 0 0 0 0 0 1
00200C93 0 0 0 0 0 0
000C0D33 1 1 0 0 0 0
008D2D83 1 0 0 0 0 0
01B02023 0 0 1 1 1 0
// load-use pairs with random gaps
00002E03 0 0 0 0 0 1
01CE0EB3 1 1 1 1 1 0
00002F03 0 0 0 0 0 1
01EF0FB3 1 1 1 1 1 0
00002083 0 0 0 0 0 1
00108133 1 1 1 1 1 0
00002183 0 0 0 0 0 1
00318233 1 1 1 1 1 0
00002283 0 0 0 0 0 1
00528333 1 1 1 1 1 0
00002383 0 0 0 0 0 1
00738433 1 1 1 1 1 0

//--- dv/pipe_ctrl_tb.sv
module pipe_ctrl_tb;
    import hazard_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int MAX_RECS    = 64;
    // word, fwd_a, fwd_a_sel, fwd_b, fwd_b_sel, bubble, gap
    localparam int REC_FIELDS  = 7;

    logic                 clk;
    logic                 rst_n;
    logic                 instr_valid;
    logic [31:0]          instr_word;
    logic                 credit_return;
    logic                 issue_valid;
    logic [31:0]          issue_word;
    logic                 fwd_a;
    logic [fwd_sel_w-1:0] fwd_a_sel;
    logic                 fwd_b;
    logic [fwd_sel_w-1:0] fwd_b_sel;
    logic                 bubble;

    logic [31:0] stim [MAX_RECS*REC_FIELDS];
    int          num_recs;
    int          credits;
    int          next_check  = 0;
    int          cycles      = 0;
    logic        bubble_seen = 1'b0;

    pipe_ctrl_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr_word    (instr_word),
        .credit_return (credit_return),
        .issue_valid   (issue_valid),
        .issue_word    (issue_word),
        .fwd_a         (fwd_a),
        .fwd_a_sel     (fwd_a_sel),
        .fwd_b         (fwd_b),
        .fwd_b_sel     (fwd_b_sel),
        .bubble        (bubble)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    task automatic report_mismatch(input string what);
        $display("FAIL at time %0t: %s", $time, what);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at first mismatch");
    endtask

    // sends the word on one producer clock only while a credit is held
    task automatic producer_cycle(input logic want, input logic [31:0] word, output logic sent);
        @(posedge clk);
        // credit_return here is still the value of the cycle just ended
        if (credit_return) begin
            credits++;
        end
        assert (credits <= QUEUE_DEPTH)
            else report_mismatch($sformatf("credit count %0d above queue depth", credits));
        sent = want && (credits > 0);
        if (sent) begin
            credits--;
        end
        instr_valid <= sent;
        instr_word  <= sent ? word : '0;
    endtask

    task automatic push_word(input logic [31:0] word);
        logic sent;
        sent = 1'b0;
        // stalls here while the queue is full
        while (!sent) begin
            producer_cycle(1'b1, word, sent);
        end
    endtask

    task automatic idle_cycles(input int n);
        logic sent;
        repeat (n) begin
            producer_cycle(1'b0, '0, sent);
        end
    endtask

    // issue side sampled mid-cycle
    always @(negedge clk) begin
        int base;
        if (rst_n && issue_valid) begin
            assert (next_check < num_recs)
                else report_mismatch("issue_valid with every record already issued");
            base = next_check * REC_FIELDS;
            assert (issue_word == stim[base])
                else report_mismatch($sformatf("record %0d issued %h, expected %h",
                    next_check, issue_word, stim[base]));
            assert (fwd_a == stim[base+1][0] && fwd_a_sel == stim[base+2][fwd_sel_w-1:0])
                else report_mismatch($sformatf("record %0d fwd_a %0b sel %0d, expected %0b sel %0d",
                    next_check, fwd_a, fwd_a_sel, stim[base+1][0], stim[base+2]));
            assert (fwd_b == stim[base+3][0] && fwd_b_sel == stim[base+4][fwd_sel_w-1:0])
                else report_mismatch($sformatf("record %0d fwd_b %0b sel %0d, expected %0b sel %0d",
                    next_check, fwd_b, fwd_b_sel, stim[base+3][0], stim[base+4]));
            // bubble belongs to the empty EX cycle just before the word
            assert (bubble_seen == stim[base+5][0] && !bubble)
                else report_mismatch($sformatf("record %0d bubble before %0b, expected %0b",
                    next_check, bubble_seen, stim[base+5][0]));
            next_check++;
        end
        bubble_seen = rst_n && bubble;
    end

    // run limit scales with the record count
    always @(posedge clk) begin
        cycles++;
        if (cycles >= num_recs * 3 + 100) begin
            $display("timeout after %0d cycles with %0d of %0d words issued",
                cycles, next_check, num_recs);
            $display("Finished with errors");
            $fatal(1, "run did not complete");
        end
    end

    initial begin
        int gap;
        instr_valid = 1'b0;
        instr_word  = '0;
        rst_n       = 1'b0;
        credits     = QUEUE_DEPTH;
        void'($urandom(43198));
        $readmemh("dv/pipe_ctrl_stimulus.txt", stim);
        // records run until the first unfilled word
        num_recs = 0;
        while (num_recs < MAX_RECS && !$isunknown(stim[num_recs*REC_FIELDS])) begin
            num_recs++;
        end
        if (num_recs == 0) begin
            $display("stimulus file dv/pipe_ctrl_stimulus.txt holds no records");
            $display("Finished with errors");
            $fatal(1, "no stimulus");
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        // pipe stays quiet until the first push
        repeat (3) begin
            idle_cycles(1);
            assert (!issue_valid && !credit_return)
                else report_mismatch("issue or credit activity before any push");
        end
        for (int r = 0; r < num_recs; r++) begin
            // idle only where the record allows it
            if (stim[r*REC_FIELDS+6] != 0) begin
                gap = $urandom % 4;
                idle_cycles(gap);
            end
            push_word(stim[r*REC_FIELDS]);
        end
        // credits keep coming back while the pipe drains
        while (next_check < num_recs) begin
            idle_cycles(1);
        end
        assert (credits == QUEUE_DEPTH)
            else report_mismatch($sformatf("credit count ends at %0d, expected %0d",
                credits, QUEUE_DEPTH));
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- rtl/hazard_pkg.sv
package hazard_pkg;

    // base opcodes, instruction bits [6:0]
    localparam logic [6:0] op_lui     = 7'b0110111;
    localparam logic [6:0] op_auipc   = 7'b0010111;
    localparam logic [6:0] op_jal     = 7'b1101111;
    localparam logic [6:0] op_jalr    = 7'b1100111;
    localparam logic [6:0] op_load    = 7'b0000011;
    localparam logic [6:0] op_store   = 7'b0100011;
    localparam logic [6:0] op_itype   = 7'b0010011;
    localparam logic [6:0] op_itype_w = 7'b0011011;
    localparam logic [6:0] op_rtype   = 7'b0110011;
    localparam logic [6:0] op_rtype_w = 7'b0111011;
    localparam logic [6:0] op_branch  = 7'b1100011;

    // register index width
    localparam int xlen_w = 5;

    // forwarding select, covers up to 4 back-end slots
    localparam int fwd_sel_w = 2;

    // one word, two layouts
    // bits [11:7] are rd for writers, low immediate for stores and branches
    typedef union packed {
        struct packed {
            logic [6:0]        funct7;
            logic [xlen_w-1:0] rs2;
            logic [xlen_w-1:0] rs1;
            logic [2:0]        funct3;
            logic [xlen_w-1:0] rd;
            logic [6:0]        opcode;
        } r_view;
        struct packed {
            logic [6:0]        imm_hi;
            logic [xlen_w-1:0] rs2;
            logic [xlen_w-1:0] rs1;
            logic [2:0]        funct3;
            logic [4:0]        imm_lo;
            logic [6:0]        opcode;
        } s_view;
    } instr_t;

    // stores and branches have no destination
    function automatic logic writes_rd(input logic [6:0] opcode);
        return (opcode != op_store) && (opcode != op_branch);
    endfunction

    // lui, auipc and jal take pc or nothing as operand a
    function automatic logic reads_rs1(input logic [6:0] opcode);
        case (opcode)
            op_jalr, op_load, op_store, op_branch,
            op_itype, op_itype_w, op_rtype, op_rtype_w: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // everything else uses an immediate as operand b
    function automatic logic reads_rs2(input logic [6:0] opcode);
        case (opcode)
            op_rtype, op_rtype_w, op_store, op_branch: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

//--- rtl/hazard_resolver.sv
module hazard_resolver #(
    parameter int NUM_STAGES = 3
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                id_valid,
    input  logic [NUM_STAGES-1:0]               hit_a,
    input  logic [NUM_STAGES-1:0]               hit_b,
    input  logic [NUM_STAGES-1:0]               is_load,
    output logic                                id_advance,
    output logic                                bubble,
    output logic                                fwd_a,
    output logic [hazard_pkg::fwd_sel_w-1:0]    fwd_a_sel,
    output logic                                fwd_b,
    output logic [hazard_pkg::fwd_sel_w-1:0]    fwd_b_sel
);
    import hazard_pkg::*;

    logic [fwd_sel_w-1:0] sel_a;
    logic [fwd_sel_w-1:0] sel_b;
    logic                 any_a;
    logic                 any_b;
    logic                 load_use;

    // priority encode, lowest index is the youngest producer
    // loop runs downward so the nearest hit is written last
    always_comb begin
        sel_a = '0;
        sel_b = '0;
        any_a = 1'b0;
        any_b = 1'b0;
        for (int k = NUM_STAGES - 1; k >= 0; k--) begin
            if (hit_a[k]) begin
                sel_a = fwd_sel_w'(k);
                any_a = 1'b1;
            end
            if (hit_b[k]) begin
                sel_b = fwd_sel_w'(k);
                any_b = 1'b1;
            end
        end
    end

    // load in EX feeding ID, data not ready yet
    // one cycle later the load sits in MEM and forwards from there
    assign load_use = id_valid && is_load[0] && (hit_a[0] || hit_b[0]);

    assign id_advance = id_valid && !load_use;

    // registered alongside slot 0 so the flags match issue_word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bubble    <= 1'b0;
            fwd_a     <= 1'b0;
            fwd_a_sel <= '0;
            fwd_b     <= 1'b0;
            fwd_b_sel <= '0;
        end else begin
            // stall cycle puts a bubble into EX
            bubble <= load_use;
            // only meaningful when a word actually moves into EX
            fwd_a  <= id_advance && any_a;
            fwd_b  <= id_advance && any_b;
            if (id_advance) begin
                fwd_a_sel <= sel_a;
                fwd_b_sel <= sel_b;
            end else begin
                fwd_a_sel <= '0;
                fwd_b_sel <= '0;
            end
        end
    end

endmodule

//--- rtl/issue_queue.sv
module issue_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid,
    input  logic [31:0]        instr_word,
    input  logic               id_advance,
    output logic               credit_return,
    output logic               id_valid,
    output hazard_pkg::instr_t id_word
);
    import hazard_pkg::*;

    localparam int ptr_w = $clog2(QUEUE_DEPTH);
    localparam int cnt_w = $clog2(QUEUE_DEPTH + 1);

    instr_t           mem [QUEUE_DEPTH];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic             empty;
    logic             id_load;
    logic             push;
    logic             pop;
    instr_t           head_word;

    // wrap for depths that are not a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (count == '0);

    // ID takes a new word when free or moving on
    // empty queue passes the incoming word straight through
    assign id_load = (!id_valid || id_advance) && (!empty || instr_valid);
    assign pop     = id_load && !empty;
    assign push    = instr_valid && !(id_load && empty);

    assign head_word = empty ? instr_t'(instr_word) : mem[rd_ptr];

    // one credit back per word entering ID
    assign credit_return = id_load;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            id_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // credits keep count within depth
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            // advance with nothing behind leaves ID empty
            if (id_load) begin
                id_valid <= 1'b1;
            end else if (id_advance) begin
                id_valid <= 1'b0;
            end
        end
    end

    // storage and ID word
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= instr_word;
        end
        if (id_load) begin
            id_word <= head_word;
        end
    end

endmodule

//--- rtl/pipe_ctrl_top.sv
module pipe_ctrl_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int NUM_STAGES  = 3
) (
    input  logic                                clk,
    input  logic                                rst_n,
    // producer side
    input  logic                                instr_valid,
    input  logic [31:0]                         instr_word,
    output logic                                credit_return,
    // issue side
    output logic                                issue_valid,
    output logic [31:0]                         issue_word,
    output logic                                fwd_a,
    output logic [hazard_pkg::fwd_sel_w-1:0]    fwd_a_sel,
    output logic                                fwd_b,
    output logic [hazard_pkg::fwd_sel_w-1:0]    fwd_b_sel,
    output logic                                bubble
);
    import hazard_pkg::*;

    logic                  id_valid;
    instr_t                id_word;
    logic                  id_advance;
    logic [NUM_STAGES-1:0] slot_valid;
    instr_t                slot_word [NUM_STAGES];
    logic [NUM_STAGES-1:0] hit_a;
    logic [NUM_STAGES-1:0] hit_b;
    logic [NUM_STAGES-1:0] is_load;

    issue_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr_word    (instr_word),
        .id_advance    (id_advance),
        .credit_return (credit_return),
        .id_valid      (id_valid),
        .id_word       (id_word)
    );

    // slot 0 is EX, each later slot follows the one before
    for (genvar k = 0; k < NUM_STAGES; k++) begin : gen_slot
        logic   in_valid;
        instr_t in_word;

        if (k == 0) begin : g_head
            // stalled ID sends a bubble
            assign in_valid = id_advance;
            assign in_word  = id_word;
        end else begin : g_chain
            assign in_valid = slot_valid[k-1];
            assign in_word  = slot_word[k-1];
        end

        stage_slot u_slot (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (in_valid),
            .in_word   (in_word),
            .id_word   (id_word),
            .out_valid (slot_valid[k]),
            .out_word  (slot_word[k]),
            .hit_a     (hit_a[k]),
            .hit_b     (hit_b[k]),
            .is_load   (is_load[k])
        );
    end

    hazard_resolver #(
        .NUM_STAGES (NUM_STAGES)
    ) u_resolver (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_valid   (id_valid),
        .hit_a      (hit_a),
        .hit_b      (hit_b),
        .is_load    (is_load),
        .id_advance (id_advance),
        .bubble     (bubble),
        .fwd_a      (fwd_a),
        .fwd_a_sel  (fwd_a_sel),
        .fwd_b      (fwd_b),
        .fwd_b_sel  (fwd_b_sel)
    );

    // issue view is the EX slot
    assign issue_valid = slot_valid[0];
    assign issue_word  = slot_word[0];

endmodule

//--- rtl/stage_slot.sv
module stage_slot (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  hazard_pkg::instr_t in_word,
    input  hazard_pkg::instr_t id_word,
    output logic               out_valid,
    output hazard_pkg::instr_t out_word,
    output logic               hit_a,
    output logic               hit_b,
    output logic               is_load
);
    import hazard_pkg::*;

    logic [xlen_w-1:0] rd;
    logic [6:0]        slot_op;
    logic              rd_live;
    logic [6:0]        id_op;
    logic [xlen_w-1:0] id_rs1;
    logic [xlen_w-1:0] id_rs2;
    logic              use_rs1;
    logic              use_rs2;

    // back end never stalls, slot moves every cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_word <= in_word;
    end

    // producer side through the R/I layout
    assign rd      = out_word.r_view.rd;
    assign slot_op = out_word.r_view.opcode;

    // x0 writes are discarded, never a dependency
    assign rd_live = out_valid && writes_rd(slot_op) && (rd != '0);

    // consumer side through the S/B layout
    // sources sit at the same bits in every format that has them
    assign id_op  = id_word.s_view.opcode;
    assign id_rs1 = id_word.s_view.rs1;
    assign id_rs2 = id_word.s_view.rs2;

    // immediate or pc operands are not register reads
    assign use_rs1 = reads_rs1(id_op);
    assign use_rs2 = reads_rs2(id_op);

    assign hit_a = rd_live && use_rs1 && (rd == id_rs1);
    assign hit_b = rd_live && use_rs2 && (rd == id_rs2);

    // load data only exists after MEM
    assign is_load = out_valid && (slot_op == op_load);

endmodule

//--- sources.f
rtl/hazard_pkg.sv
rtl/issue_queue.sv
rtl/stage_slot.sv
rtl/hazard_resolver.sv
rtl/pipe_ctrl_top.sv
dv/pipe_ctrl_properties.sv
dv/pipe_ctrl_tb.sv
